//--- lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// pipeline width
`define ISSUE_WIDTH 2

// cache and ram geometry, one word per line
`define DC_LINES_LOG2 4
`define RAM_WORDS_LOG2 6
`define REFILL_LATENCY 3

// aluop codes, zero is left free for a bubble
`define ALU_ADD 8'h01
`define ALU_LDB 8'h20
`define ALU_LDBU 8'h21
`define ALU_LDH 8'h22
`define ALU_LDHU 8'h23
`define ALU_LDW 8'h24
`define ALU_LLW 8'h25
`define ALU_STB 8'h30
`define ALU_STH 8'h31
`define ALU_STW 8'h32

`endif

//--- pipeline_types.sv
`default_nettype none

package pipeline_types;

    // data and address words
    typedef logic [31:0] bus32_t;

    // architectural register index
    typedef logic [4:0] reg_addr_t;

    typedef logic [7:0] aluop_t;

    // one bit per byte lane
    typedef logic [3:0] byte_en_t;

    // refill fsm of the data cache
    typedef enum logic [1:0] {
        DC_IDLE,
        DC_REFILL,
        DC_FILL_DONE
    } dcache_state_t;

endpackage

`default_nettype wire

//--- ex_mem_reg.sv
`default_nettype none
`include "lsu_macros.svh"

module ex_mem_reg
    import pipeline_types::*;
(
    input  logic                            clk,
    input  logic                            reset_i,
    input  logic                            stall_i,
    input  logic      [`ISSUE_WIDTH-1:0]    slot_valid_i,
    input  logic      [`ISSUE_WIDTH-1:0]    reg_write_en_i,
    input  aluop_t    [`ISSUE_WIDTH-1:0]    aluop_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0]    mem_addr_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0]    store_data_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0]    reg_write_data_i,
    input  reg_addr_t [`ISSUE_WIDTH-1:0]    reg_write_addr_i,
    output logic      [`ISSUE_WIDTH-1:0]    slot_valid_o,
    output logic      [`ISSUE_WIDTH-1:0]    reg_write_en_o,
    output aluop_t    [`ISSUE_WIDTH-1:0]    aluop_o,
    output bus32_t    [`ISSUE_WIDTH-1:0]    mem_addr_o,
    output bus32_t    [`ISSUE_WIDTH-1:0]    store_data_o,
    output bus32_t    [`ISSUE_WIDTH-1:0]    reg_write_data_o,
    output reg_addr_t [`ISSUE_WIDTH-1:0]    reg_write_addr_o
);

    // invalid slots become bubbles: no write, no memory access
    always_ff @(posedge clk) begin
        if (reset_i) begin
            slot_valid_o <= '0;
            reg_write_en_o <= '0;
            aluop_o <= '0;
        end else if (!stall_i) begin
            slot_valid_o <= slot_valid_i;
            reg_write_en_o <= slot_valid_i & reg_write_en_i;
            for (int i = 0; i < `ISSUE_WIDTH; i++) begin
                aluop_o[i] <= slot_valid_i[i] ? aluop_i[i] : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            mem_addr_o <= mem_addr_i;
            store_data_o <= store_data_i;
            reg_write_data_o <= reg_write_data_i;
            reg_write_addr_o <= reg_write_addr_i;
        end
    end

endmodule

`default_nettype wire

//--- backing_ram.sv
`default_nettype none
`include "lsu_macros.svh"

module backing_ram
    import pipeline_types::*;
(
    input  logic                       clk,
    input  logic                       rd_req_i,
    input  logic [`RAM_WORDS_LOG2-1:0] rd_addr_i,
    input  logic [`RAM_WORDS_LOG2-1:0] wr_addr_i,
    input  logic                       wr_en_i,
    input  bus32_t                     wr_data_i,
    input  byte_en_t                   wr_be_i,
    output logic                       rd_valid_o,
    output bus32_t                     rd_data_o
);

    bus32_t mem_q [2 ** `RAM_WORDS_LOG2];
    logic [`REFILL_LATENCY-1:0] rd_valid_q;
    bus32_t rd_data_q [`REFILL_LATENCY];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_be_i[b]) begin
                    mem_q[wr_addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

    // read pipeline, data sampled when the request is seen
    always_ff @(posedge clk) begin
        rd_valid_q <= {rd_valid_q[`REFILL_LATENCY-2:0], rd_req_i};
        rd_data_q[0] <= mem_q[rd_addr_i];
        for (int s = 1; s < `REFILL_LATENCY; s++) begin
            rd_data_q[s] <= rd_data_q[s-1];
        end
    end

    assign rd_valid_o = rd_valid_q[`REFILL_LATENCY-1];
    assign rd_data_o = rd_data_q[`REFILL_LATENCY-1];

endmodule

`default_nettype wire

//--- dcache.sv
`default_nettype none
`include "lsu_macros.svh"

module dcache
    import pipeline_types::*;
(
    input  logic     clk,
    input  logic     reset_i,
    input  logic     req_i,
    input  logic     we_i,
    input  bus32_t   addr_i,
    input  bus32_t   wdata_i,
    input  byte_en_t be_i,
    output logic     data_ok_o,
    output logic     cache_miss_o,
    output bus32_t   rdata_o,
    output logic     ram_rd_req_o,
    output logic     ram_wr_en_o,
    output bus32_t   ram_rd_addr_o,
    output bus32_t   ram_wr_addr_o,
    output bus32_t   ram_wr_data_o,
    output byte_en_t ram_wr_be_o,
    input  logic     ram_rd_valid_i,
    input  bus32_t   ram_rd_data_i
);

    localparam int LINES = 2 ** `DC_LINES_LOG2;
    localparam int TAG_W = 32 - `DC_LINES_LOG2 - 2;

    logic [`DC_LINES_LOG2-1:0] index;
    logic [TAG_W-1:0] tag;
    logic [LINES-1:0] valid_q;
    logic [TAG_W-1:0] tag_q [LINES];
    bus32_t data_q [LINES];
    dcache_state_t state_q;
    dcache_state_t state_d;
    logic line_match;
    logic rd_miss;
    logic refill_done;
    bus32_t wdata_lane;
    bus32_t merged;

    assign index = addr_i[`DC_LINES_LOG2+1:2];
    assign tag = addr_i[31:`DC_LINES_LOG2+2];
    assign line_match = valid_q[index] && (tag_q[index] == tag);
    assign rd_miss = req_i && !we_i && !line_match;
    assign refill_done = (state_q == DC_REFILL) && ram_rd_valid_i;

    // stores are never held up, loads only on a hit
    assign data_ok_o = req_i && (we_i || line_match);
    assign cache_miss_o = rd_miss;
    assign rdata_o = data_q[index];

    // store data comes right aligned, move it onto its byte lanes
    assign wdata_lane = wdata_i << {addr_i[1:0], 3'b000};

    assign ram_rd_req_o = (state_q == DC_IDLE) && rd_miss;
    assign ram_rd_addr_o = {2'b00, addr_i[31:2]};
    assign ram_wr_en_o = req_i && we_i;
    assign ram_wr_addr_o = {2'b00, addr_i[31:2]};
    assign ram_wr_data_o = wdata_lane;
    assign ram_wr_be_o = be_i;

    always_comb begin
        merged = data_q[index];
        for (int b = 0; b < 4; b++) begin
            if (be_i[b]) begin
                merged[8*b +: 8] = wdata_lane[8*b +: 8];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            DC_IDLE: begin
                if (rd_miss) begin
                    state_d = DC_REFILL;
                end
            end
            DC_REFILL: begin
                if (ram_rd_valid_i) begin
                    state_d = DC_FILL_DONE;
                end
            end
            default: state_d = DC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= DC_IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (refill_done) begin
                valid_q[index] <= 1'b1;
            end
        end
    end

    // write-through, no allocate on a store miss
    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_q[index] <= tag;
            data_q[index] <= ram_rd_data_i;
        end else if (ram_wr_en_o && line_match) begin
            data_q[index] <= merged;
        end
    end

    // one read in flight, answered after exactly the ram latency
    assert property (@(posedge clk) disable iff (reset_i)
        ram_rd_req_o |=> (state_q == DC_REFILL && !ram_rd_req_o) [*`REFILL_LATENCY]
            ##1 (state_q == DC_FILL_DONE));

endmodule

`default_nettype wire

//--- mem_stage.sv
`default_nettype none
`include "lsu_macros.svh"

module mem_stage
    import pipeline_types::*;
(
    input  logic      [`ISSUE_WIDTH-1:0] reg_write_en_i,
    input  reg_addr_t [`ISSUE_WIDTH-1:0] reg_write_addr_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0] reg_write_data_i,
    input  aluop_t                       aluop_i,
    input  bus32_t                       mem_addr_i,
    input  logic                         data_ok_i,
    input  logic                         cache_miss_i,
    input  bus32_t                       cache_rdata_i,
    output logic                         mem_req_o,
    output logic                         mem_we_o,
    output byte_en_t                     mem_be_o,
    output logic                         pause_mem_o,
    output logic      [`ISSUE_WIDTH-1:0] wb_we_o,
    output reg_addr_t [`ISSUE_WIDTH-1:0] wb_addr_o,
    output bus32_t    [`ISSUE_WIDTH-1:0] wb_data_o
);

    bus32_t cache_data;
    bus32_t slot0_data;
    logic load_hit;
    logic is_load;
    logic is_store;
    logic half_ok;
    logic word_ok;
    logic [7:0] byte_val;
    logic [15:0] half_val;

    assign load_hit = !cache_miss_i && data_ok_i;
    assign cache_data = load_hit ? cache_rdata_i : 32'b0;
    assign half_ok = !mem_addr_i[0];
    assign word_ok = (mem_addr_i[1:0] == 2'b00);
    assign half_val = mem_addr_i[1] ? cache_data[31:16] : cache_data[15:0];

    always_comb begin
        case (mem_addr_i[1:0])
            2'b00: byte_val = cache_data[7:0];
            2'b01: byte_val = cache_data[15:8];
            2'b10: byte_val = cache_data[23:16];
            default: byte_val = cache_data[31:24];
        endcase
    end

    // misaligned halfword and word loads give zero
    always_comb begin
        is_load = 1'b1;
        case (aluop_i)
            `ALU_LDB: slot0_data = {{24{byte_val[7]}}, byte_val};
            `ALU_LDBU: slot0_data = {24'b0, byte_val};
            `ALU_LDH: slot0_data = half_ok ? {{16{half_val[15]}}, half_val} : 32'b0;
            `ALU_LDHU: slot0_data = half_ok ? {16'b0, half_val} : 32'b0;
            `ALU_LDW, `ALU_LLW: slot0_data = word_ok ? cache_data : 32'b0;
            default: begin
                is_load = 1'b0;
                slot0_data = reg_write_data_i[0];
            end
        endcase
    end

    assign is_store = (aluop_i == `ALU_STB) || (aluop_i == `ALU_STH) || (aluop_i == `ALU_STW);

    always_comb begin
        case (aluop_i)
            `ALU_STB: mem_be_o = 4'b0001 << mem_addr_i[1:0];
            `ALU_STH: mem_be_o = half_ok ? (mem_addr_i[1] ? 4'b1100 : 4'b0011) : 4'b0000;
            `ALU_STW: mem_be_o = word_ok ? 4'b1111 : 4'b0000;
            default: mem_be_o = 4'b0000;
        endcase
    end

    assign mem_req_o = is_load || is_store;
    assign mem_we_o = is_store;
    assign pause_mem_o = is_load && !load_hit;

    assign wb_we_o = reg_write_en_i;
    assign wb_addr_o = reg_write_addr_i;
    assign wb_data_o[0] = slot0_data;

    // only slot 0 reaches memory
    for (genvar i = 1; i < `ISSUE_WIDTH; i++) begin : g_pass
        assign wb_data_o[i] = reg_write_data_i[i];
    end

    // a pause is only ever a load that the cache reports as a miss
    assert final (!pause_mem_o || (cache_miss_i &&
        aluop_i inside {`ALU_LDB, `ALU_LDBU, `ALU_LDH, `ALU_LDHU, `ALU_LDW, `ALU_LLW}));

endmodule

`default_nettype wire

//--- mem_wb_reg.sv
`default_nettype none
`include "lsu_macros.svh"

module mem_wb_reg
    import pipeline_types::*;
(
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         stall_i,
    input  logic      [`ISSUE_WIDTH-1:0] we_i,
    input  reg_addr_t [`ISSUE_WIDTH-1:0] addr_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0] data_i,
    output logic      [`ISSUE_WIDTH-1:0] wb_we_o,
    output reg_addr_t [`ISSUE_WIDTH-1:0] wb_addr_o,
    output bus32_t    [`ISSUE_WIDTH-1:0] wb_data_o
);

    // bubble while the memory stage is paused
    always_ff @(posedge clk) begin
        if (reset_i || stall_i) begin
            wb_we_o <= '0;
        end else begin
            wb_we_o <= we_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= addr_i;
        wb_data_o <= data_i;
    end

endmodule

`default_nettype wire

//--- lsu_top.sv
`default_nettype none
`include "lsu_macros.svh"

module lsu_top
    import pipeline_types::*;
(
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic      [`ISSUE_WIDTH-1:0] slot_valid_i,
    input  aluop_t    [`ISSUE_WIDTH-1:0] aluop_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0] mem_addr_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0] store_data_i,
    input  logic      [`ISSUE_WIDTH-1:0] reg_write_en_i,
    input  reg_addr_t [`ISSUE_WIDTH-1:0] reg_write_addr_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0] reg_write_data_i,
    output logic                         stall_o,
    output logic      [`ISSUE_WIDTH-1:0] fwd_we_o,
    output reg_addr_t [`ISSUE_WIDTH-1:0] fwd_addr_o,
    output bus32_t    [`ISSUE_WIDTH-1:0] fwd_data_o,
    output logic      [`ISSUE_WIDTH-1:0] wb_we_o,
    output reg_addr_t [`ISSUE_WIDTH-1:0] wb_addr_o,
    output bus32_t    [`ISSUE_WIDTH-1:0] wb_data_o
);

    logic      [`ISSUE_WIDTH-1:0] ex_we;
    aluop_t    [`ISSUE_WIDTH-1:0] ex_aluop;
    bus32_t    [`ISSUE_WIDTH-1:0] ex_mem_addr;
    bus32_t    [`ISSUE_WIDTH-1:0] ex_store_data;
    bus32_t    [`ISSUE_WIDTH-1:0] ex_data;
    reg_addr_t [`ISSUE_WIDTH-1:0] ex_addr;

    logic mem_req;
    logic mem_we;
    byte_en_t mem_be;
    logic data_ok;
    logic cache_miss;
    bus32_t cache_rdata;

    logic ram_rd_req;
    logic ram_rd_valid;
    logic ram_wr_en;
    bus32_t ram_rd_addr;
    bus32_t ram_wr_addr;
    bus32_t ram_wr_data;
    bus32_t ram_rd_data;
    byte_en_t ram_wr_be;

    ex_mem_reg i_ex_mem_reg (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (stall_o),
        .slot_valid_i     (slot_valid_i),
        .reg_write_en_i   (reg_write_en_i),
        .aluop_i          (aluop_i),
        .mem_addr_i       (mem_addr_i),
        .store_data_i     (store_data_i),
        .reg_write_data_i (reg_write_data_i),
        .reg_write_addr_i (reg_write_addr_i),
        .slot_valid_o     (),
        .reg_write_en_o   (ex_we),
        .aluop_o          (ex_aluop),
        .mem_addr_o       (ex_mem_addr),
        .store_data_o     (ex_store_data),
        .reg_write_data_o (ex_data),
        .reg_write_addr_o (ex_addr)
    );

    // forwarding taps the memory stage result directly
    mem_stage i_mem_stage (
        .reg_write_en_i   (ex_we),
        .reg_write_addr_i (ex_addr),
        .reg_write_data_i (ex_data),
        .aluop_i          (ex_aluop[0]),
        .mem_addr_i       (ex_mem_addr[0]),
        .data_ok_i        (data_ok),
        .cache_miss_i     (cache_miss),
        .cache_rdata_i    (cache_rdata),
        .mem_req_o        (mem_req),
        .mem_we_o         (mem_we),
        .mem_be_o         (mem_be),
        .pause_mem_o      (stall_o),
        .wb_we_o          (fwd_we_o),
        .wb_addr_o        (fwd_addr_o),
        .wb_data_o        (fwd_data_o)
    );

    dcache i_dcache (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_i          (mem_req),
        .we_i           (mem_we),
        .addr_i         (ex_mem_addr[0]),
        .wdata_i        (ex_store_data[0]),
        .be_i           (mem_be),
        .data_ok_o      (data_ok),
        .cache_miss_o   (cache_miss),
        .rdata_o        (cache_rdata),
        .ram_rd_req_o   (ram_rd_req),
        .ram_wr_en_o    (ram_wr_en),
        .ram_rd_addr_o  (ram_rd_addr),
        .ram_wr_addr_o  (ram_wr_addr),
        .ram_wr_data_o  (ram_wr_data),
        .ram_wr_be_o    (ram_wr_be),
        .ram_rd_valid_i (ram_rd_valid),
        .ram_rd_data_i  (ram_rd_data)
    );

    backing_ram i_backing_ram (
        .clk        (clk),
        .rd_req_i   (ram_rd_req),
        .rd_addr_i  (ram_rd_addr[`RAM_WORDS_LOG2-1:0]),
        .wr_addr_i  (ram_wr_addr[`RAM_WORDS_LOG2-1:0]),
        .wr_en_i    (ram_wr_en),
        .wr_data_i  (ram_wr_data),
        .wr_be_i    (ram_wr_be),
        .rd_valid_o (ram_rd_valid),
        .rd_data_o  (ram_rd_data)
    );

    mem_wb_reg i_mem_wb_reg (
        .clk       (clk),
        .reset_i   (reset_i),
        .stall_i   (stall_o),
        .we_i      (fwd_we_o),
        .addr_i    (fwd_addr_o),
        .data_i    (fwd_data_o),
        .wb_we_o   (wb_we_o),
        .wb_addr_o (wb_addr_o),
        .wb_data_o (wb_data_o)
    );

endmodule

`default_nettype wire

//--- tb_lsu_checker.sv
`default_nettype none
`include "lsu_macros.svh"

module tb_lsu_checker
    import pipeline_types::*;
(
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         done_i,
    input  logic      [`ISSUE_WIDTH-1:0] slot_valid_i,
    input  aluop_t    [`ISSUE_WIDTH-1:0] aluop_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0] mem_addr_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0] store_data_i,
    input  logic      [`ISSUE_WIDTH-1:0] reg_write_en_i,
    input  reg_addr_t [`ISSUE_WIDTH-1:0] reg_write_addr_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0] reg_write_data_i,
    input  logic                         stall_i,
    input  logic      [`ISSUE_WIDTH-1:0] fwd_we_i,
    input  reg_addr_t [`ISSUE_WIDTH-1:0] fwd_addr_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0] fwd_data_i,
    input  logic      [`ISSUE_WIDTH-1:0] wb_we_i,
    input  reg_addr_t [`ISSUE_WIDTH-1:0] wb_addr_i,
    input  bus32_t    [`ISSUE_WIDTH-1:0] wb_data_i,
    output int                           error_count_o,
    output logic                         report_done_o
);

    // byte-addressed memory model, little endian
    logic [7:0] mem_model [256];

    // which ram word each direct-mapped cache line holds
    logic [`RAM_WORDS_LOG2-1:0] line_word [2 ** `DC_LINES_LOG2];
    logic [2 ** `DC_LINES_LOG2 - 1:0] line_valid = '0;

    // stall due from the bundle that enters the memory stage next
    logic expect_stall = 1'b0;
    logic first_look = 1'b0;

    // one entry per accepted bundle, mask marks the valid slots
    logic      [`ISSUE_WIDTH-1:0] mask_q [$];
    logic      [`ISSUE_WIDTH-1:0] we_q [$];
    reg_addr_t [`ISSUE_WIDTH-1:0] addr_q [$];
    bus32_t    [`ISSUE_WIDTH-1:0] data_q [$];

    // what wb must show after the next edge
    logic      [`ISSUE_WIDTH-1:0] exp_mask = '0;
    logic      [`ISSUE_WIDTH-1:0] exp_we = '0;
    reg_addr_t [`ISSUE_WIDTH-1:0] exp_addr = '0;
    bus32_t    [`ISSUE_WIDTH-1:0] exp_data = '0;

    int checks = 0;
    int loads = 0;
    int stores = 0;
    int stall_cycles = 0;

    initial begin
        error_count_o = 0;
        report_done_o = 1'b0;
    end

    function automatic logic is_load_op(aluop_t op);
        return op inside {`ALU_LDB, `ALU_LDBU, `ALU_LDH, `ALU_LDHU, `ALU_LDW, `ALU_LLW};
    endfunction

    // misaligned halfword and word loads read as zero
    function automatic bus32_t load_value(aluop_t op, logic [7:0] a);
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        b0 = mem_model[a];
        b1 = mem_model[a + 8'd1];
        b2 = mem_model[a + 8'd2];
        b3 = mem_model[a + 8'd3];
        case (op)
            `ALU_LDB: return {{24{b0[7]}}, b0};
            `ALU_LDBU: return {24'b0, b0};
            `ALU_LDH: return a[0] ? 32'b0 : {{16{b1[7]}}, b1, b0};
            `ALU_LDHU: return a[0] ? 32'b0 : {16'b0, b1, b0};
            default: return (a[1:0] != 2'b00) ? 32'b0 : {b3, b2, b1, b0};
        endcase
    endfunction

    // a load misses unless its line holds the word already
    task automatic predict_stall(logic [7:0] a);
        logic [`RAM_WORDS_LOG2-1:0] word;
        logic [`DC_LINES_LOG2-1:0] line;
        word = a[`RAM_WORDS_LOG2+1:2];
        line = word[`DC_LINES_LOG2-1:0];
        expect_stall = !(line_valid[line] && line_word[line] == word);
        line_valid[line] = 1'b1;
        line_word[line] = word;
    endtask

    // store data is right aligned, misaligned stores write nothing
    task automatic store_model(aluop_t op, logic [7:0] a, bus32_t d);
        case (op)
            `ALU_STB: begin
                mem_model[a] = d[7:0];
                stores++;
            end
            `ALU_STH: begin
                if (!a[0]) begin
                    mem_model[a] = d[7:0];
                    mem_model[a + 8'd1] = d[15:8];
                end
                stores++;
            end
            `ALU_STW: begin
                if (a[1:0] == 2'b00) begin
                    for (int k = 0; k < 4; k++) begin
                        mem_model[a + 8'(k)] = d[8*k +: 8];
                    end
                end
                stores++;
            end
            default: ;
        endcase
    endtask

    task automatic accept_bundle();
        bus32_t [`ISSUE_WIDTH-1:0] data;
        data = reg_write_data_i;
        expect_stall = 1'b0;
        if (slot_valid_i[0] && is_load_op(aluop_i[0])) begin
            data[0] = load_value(aluop_i[0], mem_addr_i[0][7:0]);
            predict_stall(mem_addr_i[0][7:0]);
            loads++;
        end
        if (slot_valid_i[0]) begin
            store_model(aluop_i[0], mem_addr_i[0][7:0], store_data_i[0]);
        end
        first_look = 1'b1;
        mask_q.push_back(slot_valid_i);
        we_q.push_back(slot_valid_i & reg_write_en_i);
        addr_q.push_back(reg_write_addr_i);
        data_q.push_back(data);
    endtask

    task automatic compare_slots(
        input string                        what,
        input logic      [`ISSUE_WIDTH-1:0] mask,
        input logic      [`ISSUE_WIDTH-1:0] we,
        input reg_addr_t [`ISSUE_WIDTH-1:0] addr,
        input bus32_t    [`ISSUE_WIDTH-1:0] data,
        input logic      [`ISSUE_WIDTH-1:0] got_we,
        input reg_addr_t [`ISSUE_WIDTH-1:0] got_addr,
        input bus32_t    [`ISSUE_WIDTH-1:0] got_data
    );
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            checks++;
            if (got_we[i] !== we[i] ||
                (mask[i] && (got_addr[i] !== addr[i] || got_data[i] !== data[i]))) begin
                error_count_o++;
                $display("Mismatch at %0t: %s slot %0d got we %b addr %0d data %h",
                         $time, what, i, got_we[i], got_addr[i], got_data[i]);
                $display("    expected we %b addr %0d data %h", we[i], addr[i], data[i]);
            end
        end
    endtask

    // everything is stable at the falling edge
    always @(negedge clk) begin
        compare_slots("wb", exp_mask, exp_we, exp_addr, exp_data, wb_we_i, wb_addr_i, wb_data_i);
        if (reset_i) begin
            if (stall_i !== 1'b0) begin
                error_count_o++;
                $display("Mismatch at %0t: stall_o is not low during reset", $time);
            end
            mask_q.delete();
            we_q.delete();
            addr_q.delete();
            data_q.delete();
            exp_mask = '0;
            exp_we = '0;
            line_valid = '0;
            first_look = 1'b0;
        end else begin
            // a bundle new to the memory stage stalls exactly when the model misses
            if (first_look && stall_i !== expect_stall) begin
                checks++;
                error_count_o++;
                $display("Mismatch at %0t: stall_o is %b but the cache model expects %b",
                         $time, stall_i, expect_stall);
            end
            first_look = 1'b0;
            if (stall_i) begin
                // held load, wb gets a bubble
                stall_cycles++;
                exp_mask = '0;
                exp_we = '0;
            end else begin
                if (we_q.size() > 0) begin
                    compare_slots("fwd", mask_q[0], we_q[0], addr_q[0], data_q[0],
                                  fwd_we_i, fwd_addr_i, fwd_data_i);
                    exp_mask = mask_q.pop_front();
                    exp_we = we_q.pop_front();
                    exp_addr = addr_q.pop_front();
                    exp_data = data_q.pop_front();
                end else begin
                    exp_mask = '0;
                    exp_we = '0;
                    compare_slots("fwd", exp_mask, exp_we, exp_addr, exp_data,
                                  fwd_we_i, fwd_addr_i, fwd_data_i);
                end
                accept_bundle();
            end
        end
        if (done_i && !report_done_o) begin
            if (stall_cycles == 0) begin
                error_count_o++;
                $display("no stall was seen, the refill path was never exercised");
            end
            $display("checks %0d, errors %0d, loads %0d, stores %0d, stall cycles %0d",
                     checks, error_count_o, loads, stores, stall_cycles);
            report_done_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- tb_lsu.sv
`default_nettype none
`include "lsu_macros.svh"

module tb_lsu
    import pipeline_types::*;
();

    localparam int STEP_TIMEOUT = 50;
    localparam int RANDOM_OPS = 800;
    localparam aluop_t OP_TABLE [10] = '{
        `ALU_LDB, `ALU_LDBU, `ALU_LDH, `ALU_LDHU, `ALU_LDW,
        `ALU_LLW, `ALU_STB, `ALU_STH, `ALU_STW, `ALU_ADD
    };

    logic clk;
    logic reset;
    logic done;
    logic report_done;
    int error_count;
    logic stall;

    logic      [`ISSUE_WIDTH-1:0] slot_valid;
    aluop_t    [`ISSUE_WIDTH-1:0] aluop;
    bus32_t    [`ISSUE_WIDTH-1:0] mem_addr;
    bus32_t    [`ISSUE_WIDTH-1:0] store_data;
    logic      [`ISSUE_WIDTH-1:0] reg_write_en;
    reg_addr_t [`ISSUE_WIDTH-1:0] reg_write_addr;
    bus32_t    [`ISSUE_WIDTH-1:0] reg_write_data;
    logic      [`ISSUE_WIDTH-1:0] fwd_we;
    reg_addr_t [`ISSUE_WIDTH-1:0] fwd_addr;
    bus32_t    [`ISSUE_WIDTH-1:0] fwd_data;
    logic      [`ISSUE_WIDTH-1:0] wb_we;
    reg_addr_t [`ISSUE_WIDTH-1:0] wb_addr;
    bus32_t    [`ISSUE_WIDTH-1:0] wb_data;

    lsu_top i_lsu_top (
        .clk              (clk),
        .reset_i          (reset),
        .slot_valid_i     (slot_valid),
        .aluop_i          (aluop),
        .mem_addr_i       (mem_addr),
        .store_data_i     (store_data),
        .reg_write_en_i   (reg_write_en),
        .reg_write_addr_i (reg_write_addr),
        .reg_write_data_i (reg_write_data),
        .stall_o          (stall),
        .fwd_we_o         (fwd_we),
        .fwd_addr_o       (fwd_addr),
        .fwd_data_o       (fwd_data),
        .wb_we_o          (wb_we),
        .wb_addr_o        (wb_addr),
        .wb_data_o        (wb_data)
    );

    tb_lsu_checker i_checker (
        .clk              (clk),
        .reset_i          (reset),
        .done_i           (done),
        .slot_valid_i     (slot_valid),
        .aluop_i          (aluop),
        .mem_addr_i       (mem_addr),
        .store_data_i     (store_data),
        .reg_write_en_i   (reg_write_en),
        .reg_write_addr_i (reg_write_addr),
        .reg_write_data_i (reg_write_data),
        .stall_i          (stall),
        .fwd_we_i         (fwd_we),
        .fwd_addr_i       (fwd_addr),
        .fwd_data_i       (fwd_data),
        .wb_we_i          (wb_we),
        .wb_addr_i        (wb_addr),
        .wb_data_i        (wb_data),
        .error_count_o    (error_count),
        .report_done_o    (report_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic bus32_t align_addr(aluop_t op, bus32_t a);
        if (op inside {`ALU_LDH, `ALU_LDHU, `ALU_STH}) begin
            return a & ~32'h1;
        end else if (op inside {`ALU_LDW, `ALU_LLW, `ALU_STW}) begin
            return a & ~32'h3;
        end
        return a;
    endfunction

    // slot 1 never touches memory
    task automatic issue_bundle(input logic [1:0] valid, input aluop_t op0,
                                input bus32_t addr0, input bus32_t sdata0);
        int waited;
        logic accepted;
        slot_valid = valid;
        aluop[0] = op0;
        aluop[1] = `ALU_ADD;
        mem_addr[0] = addr0;
        mem_addr[1] = $urandom;
        store_data[0] = sdata0;
        store_data[1] = $urandom;
        reg_write_en = 2'($urandom_range(3));
        reg_write_addr[0] = 5'($urandom);
        reg_write_addr[1] = 5'($urandom);
        reg_write_data[0] = $urandom;
        reg_write_data[1] = $urandom;
        waited = 0;
        accepted = 1'b0;
        while (!accepted && waited < STEP_TIMEOUT) begin
            @(negedge clk);
            accepted = !stall;
            @(posedge clk);
            #1;
            waited++;
        end
        if (!accepted) begin
            $display("timeout: stall_o stayed high for %0d cycles at time %0t", waited, $time);
            $display("TB FAILED");
            $finish;
        end
    endtask

    initial begin
        int waited;
        aluop_t op;
        logic [1:0] valid;
        void'($urandom(32'h914a));
        reset = 1'b1;
        done = 1'b0;
        slot_valid = '0;
        aluop = '0;
        mem_addr = '0;
        store_data = '0;
        reg_write_en = '0;
        reg_write_addr = '0;
        reg_write_data = '0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        // give every ram word a defined value
        for (int w = 0; w < 2 ** `RAM_WORDS_LOG2; w++) begin
            issue_bundle(2'b11, `ALU_STW, 32'(w * 4), $urandom);
        end

        for (int n = 0; n < RANDOM_OPS; n++) begin
            op = OP_TABLE[$urandom_range(9)];
            valid[0] = ($urandom_range(7) != 0);
            valid[1] = 1'($urandom_range(1));
            issue_bundle(valid, op, align_addr(op, $urandom_range(255)), $urandom);
        end

        // two bubbles push the last result through wb
        issue_bundle(2'b00, `ALU_ADD, '0, '0);
        issue_bundle(2'b00, `ALU_ADD, '0, '0);
        done = 1'b1;
        waited = 0;
        while (!report_done && waited < STEP_TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!report_done) begin
            $display("timeout: the checker never delivered its report");
            $display("TB FAILED");
        end else if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+.
pipeline_types.sv
ex_mem_reg.sv
backing_ram.sv
dcache.sv
mem_stage.sv
mem_wb_reg.sv
lsu_top.sv
tb_lsu_checker.sv
tb_lsu.sv

//--- Bender.yml
package:
  name: lsu_mem_stage

sources:
  - include_dirs:
      - .
    files:
      - pipeline_types.sv
      - ex_mem_reg.sv
      - backing_ram.sv
      - dcache.sv
      - mem_stage.sv
      - mem_wb_reg.sv
      - lsu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lsu_checker.sv
      - tb_lsu.sv
